/* ctrl_top.f */
+incdir+.
ctrl_pkg.sv
ctrl_map_pkg.sv
reg_bus_if.sv
ctrl_regfile.sv
ctrl_registers.sv
core_sleep_ctrl.sv
ctrl_top.sv
tb_clk_gen.sv
ctrl_top_chk.sv
ctrl_top_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the cluster control testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module ctrl_top_tb -f ctrl_top.f -o ctrl_top_sim
./obj_dir/ctrl_top_sim | tee sim.log
if grep -q "Simulation finished: PASS" sim.log; then
  echo "run passed"
else
  echo "run failed"
  exit 1
fi

/* ctrl_top_tb.sv */
// ##############################
// cluster control testbench
// random register traffic and
// wfi/wake against a model
// ##############################

`include "ctrl_macros.svh"

module ctrl_top_tb import ctrl_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CORES  = `CTRL_NUM_CORES;
  localparam int RO_ITERS   = 16;
  localparam int STRB_ITERS = 16;
  localparam int WAKE_ITERS = 16;
  localparam int PEND_ITERS = 4;
  localparam int B2B_ITERS  = 64;

  // cycles per test as driven by the test tasks below
  localparam int TEST_CYCLES = 4 + 5 + (RO_ITERS + 5) + (2 * STRB_ITERS + 1)
                             + (2 + 3 * WAKE_ITERS) + 6 * PEND_ITERS + (B2B_ITERS + 1);
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  localparam addr_t WAKE_ADDR = addr_t'('hc);

  logic       clk;
  logic       rst_n;
  logic       req;
  logic       we;
  addr_t      addr;
  data_t      wdata;
  strb_t      wstrb;
  core_mask_t wfi;
  logic       rvalid;
  data_t      rdata;
  logic       err;
  core_mask_t awake;

  // model of registers, wake pulse and core states
  data_t      m_regs [4];
  logic       m_wake_wr;
  core_mask_t m_asleep;
  core_mask_t m_pend;
  logic       exp_rvalid;
  data_t      exp_rdata;
  logic       exp_err;
  core_mask_t exp_awake;

  logic [31:0] lcg_state;
  string       test_name;
  int          test_checks;
  int          test_errors;
  int          total_errors;
  int          tests_passed;
  int          tests_failed;
  int          cycle_cnt;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ctrl_top UUT (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .reg_req_i    (req),
    .reg_we_i     (we),
    .reg_addr_i   (addr),
    .reg_wdata_i  (wdata),
    .reg_wstrb_i  (wstrb),
    .reg_rvalid_o (rvalid),
    .reg_rdata_o  (rdata),
    .reg_err_o    (err),
    .wfi_i        (wfi),
    .core_awake_o (awake)
  );

  // lcg step with the upper half folded down to stir the weak low bits
  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);
  endfunction

  // register contents out of reset
  function automatic data_t reset_value(input int r);
    case (r)
      0:       return data_t'(`CTRL_TCDM_BASE);
      1:       return data_t'(`CTRL_TCDM_BASE + `CTRL_TCDM_SIZE);
      2:       return data_t'(NUM_CORES);
      default: return '0;
    endcase
  endfunction

  // an index wakes one core and all ones wakes them all
  function automatic core_mask_t wake_decode(input data_t v);
    if (v < data_t'(NUM_CORES)) begin
      return core_mask_t'(1) << v;
    end
    if (v == '1) begin
      return '1;
    end
    return '0;
  endfunction

  function automatic data_t merge_bytes(input data_t old_v, input data_t new_v, input strb_t s);
    data_t res;
    res = old_v;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (s[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  // advance the model by one clock with the inputs now on the bus
  task automatic model_step();
    core_mask_t pulse;
    logic [1:0] idx;
    logic       refused;
    // pulse comes from a wake-up write in the previous cycle
    pulse = m_wake_wr ? wake_decode(m_regs[3]) : '0;
    for (int c = 0; c < NUM_CORES; c++) begin
      if (m_asleep[c]) begin
        if (pulse[c]) begin
          m_asleep[c] = 1'b0;
          m_pend[c]   = 1'b0;
        end
      end else if (wfi[c]) begin
        if (m_pend[c] || pulse[c]) begin
          m_pend[c] = 1'b0;
        end else begin
          m_asleep[c] = 1'b1;
        end
      end else if (pulse[c]) begin
        m_pend[c] = 1'b1;
      end
    end
    exp_awake = ~m_asleep;
    // only offsets 0x0..0xc exist and only wake-up is writable
    idx        = addr[3:2];
    refused    = (addr >= addr_t'('h10)) || (we && idx != 2'd3 && wstrb != '0);
    exp_rvalid = req;
    exp_err    = req && refused;
    exp_rdata  = (req && !we && !refused) ? m_regs[idx] : '0;
    m_wake_wr  = req && we && !refused && idx == 2'd3 && wstrb != '0;
    if (req && we && !refused) begin
      m_regs[idx] = merge_bytes(m_regs[idx], wdata, wstrb);
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    test_checks++;
    assert (actual === expected) else begin
      $display("FAILED %s %s: expected %h actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  // drive one cycle and compare the registered outputs after the edge
  task automatic bus_cycle(input logic r, input logic w, input addr_t a, input data_t d,
                           input strb_t s, input core_mask_t f);
    req   = r;
    we    = w;
    addr  = a;
    wdata = d;
    wstrb = s;
    wfi   = f;
    model_step();
    @(posedge clk);
    #1;
    check_value("rvalid", exp_rvalid, rvalid);
    check_value("err", exp_err, err);
    if (exp_rvalid) begin
      check_value("rdata", exp_rdata, rdata);
    end
    check_value("awake", exp_awake, awake);
  endtask

  task automatic read_reg(input addr_t a);
    bus_cycle(1'b1, 1'b0, a, '0, '0, '0);
  endtask

  task automatic write_reg(input addr_t a, input data_t d, input strb_t s);
    bus_cycle(1'b1, 1'b1, a, d, s, '0);
  endtask

  task automatic idle_cycle();
    bus_cycle(1'b0, 1'b0, '0, '0, '0, '0);
  endtask

  task automatic wfi_cycle(input core_mask_t f);
    bus_cycle(1'b0, 1'b0, '0, '0, '0, f);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic finish_test();
    total_errors += test_errors;
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s done, %0d checks, no errors", test_name, test_checks);
    end else begin
      tests_failed++;
      $display("test %s done, %0d checks, %0d errors", test_name, test_checks, test_errors);
    end
  endtask

  task automatic reset_readback();
    start_test("reset_values");
    for (int r = 0; r < 4; r++) begin
      read_reg(addr_t'(4 * r));
    end
    idle_cycle();
    finish_test();
  endtask

  task automatic protect_read_only();
    logic [31:0] r;
    addr_t       a;
    strb_t       s;
    start_test("read_only");
    for (int i = 0; i < RO_ITERS; i++) begin
      r = rand32();
      if (r[1:0] != 2'd3) begin
        a = addr_t'({r[1:0], 2'b00});
      end else begin
        // word aligned address above the map
        a = addr_t'('h10) | (addr_t'(r[15:8]) & addr_t'('hfc));
      end
      s = strb_t'(r[19:16]);
      if (s == '0) begin
        s = '1;
      end
      // out-of-map reads are refused as well
      bus_cycle(1'b1, !(r[1:0] == 2'd3 && r[20]), a, rand32(), s, '0);
    end
    for (int j = 0; j < 4; j++) begin
      read_reg(addr_t'(4 * j));
    end
    idle_cycle();
    finish_test();
  endtask

  task automatic merge_byte_strobes();
    logic [31:0] r;
    start_test("byte_strobes");
    for (int i = 0; i < STRB_ITERS; i++) begin
      r = rand32();
      write_reg(WAKE_ADDR, rand32(), strb_t'(r[3:0]));
      read_reg(WAKE_ADDR);
    end
    idle_cycle();
    finish_test();
  endtask

  task automatic wake_sleeping_cores();
    logic [31:0] r;
    data_t       v;
    start_test("wake_decode");
    // the first wfi may only clear a pending wake
    wfi_cycle('1);
    wfi_cycle('1);
    check_value("all asleep", '0, awake);
    for (int i = 0; i < WAKE_ITERS; i++) begin
      r = rand32();
      case (r[1:0])
        2'd0:    v = data_t'(r[31:8] % NUM_CORES);
        2'd1:    v = '1;
        2'd2:    v = data_t'(NUM_CORES) + data_t'(r[7:4]);
        default: v = rand32();
      endcase
      write_reg(WAKE_ADDR, v, '1);
      idle_cycle();
      // write in cycle N shows on awake from N+2
      check_value("woken cores", wake_decode(v), awake);
      wfi_cycle('1);
    end
    finish_test();
  endtask

  task automatic hold_pending_wake();
    int k;
    start_test("pending_wake");
    for (int i = 0; i < PEND_ITERS; i++) begin
      k = int'(rand32() % NUM_CORES);
      write_reg(WAKE_ADDR, data_t'(k), '1);
      idle_cycle();
      check_value("woken core", 32'd1, 32'(awake[k]));
      // second wake hits a running core
      write_reg(WAKE_ADDR, data_t'(k), '1);
      idle_cycle();
      wfi_cycle(core_mask_t'(1) << k);
      check_value("awake after first wfi", 32'd1, 32'(awake[k]));
      wfi_cycle(core_mask_t'(1) << k);
      check_value("asleep after second wfi", 32'd0, 32'(awake[k]));
    end
    finish_test();
  endtask

  task automatic mixed_traffic();
    logic [31:0] r;
    addr_t       a;
    start_test("back_to_back");
    for (int i = 0; i < B2B_ITERS; i++) begin
      r = rand32();
      if (r[2:0] < 3'd6) begin
        a = addr_t'({r[4:3], 2'b00});
      end else begin
        a = addr_t'('h10) | (addr_t'(r[15:8]) & addr_t'('hfc));
      end
      // sparse random wfi alongside the bus traffic
      bus_cycle(1'b1, r[5], a, rand32(), strb_t'(r[9:6]), core_mask_t'(r[23:16] & r[31:24]));
    end
    idle_cycle();
    finish_test();
  endtask

  // watchdog on the total test length
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    lcg_state    = 32'h4b40d23b;
    cycle_cnt    = 0;
    total_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    wstrb = '0;
    wfi   = '0;
    // model starts in the reset state
    for (int r = 0; r < 4; r++) begin
      m_regs[r] = reset_value(r);
    end
    m_wake_wr = 1'b0;
    m_asleep  = '0;
    m_pend    = '0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;
    reset_readback();
    protect_read_only();
    merge_byte_strobes();
    wake_sleeping_cores();
    hold_pending_wake();
    mixed_traffic();
    $display("%0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* ctrl_top_chk.sv */
// ##############################
// cluster control port checks
// bus response timing and the
// awake mask out of reset
// ##############################

module ctrl_top_chk
  import ctrl_pkg::*;
(
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       req_i,
  input logic       rvalid_i,
  input logic       err_i,
  input core_mask_t core_awake_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // every request gets exactly one response, one cycle later
  rvalid_follows_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rvalid_i == $past(req_i)
  ) else $error("rvalid is not req delayed by one cycle");

  // err only qualifies a response
  err_needs_rvalid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) err_i |-> rvalid_i
  ) else $error("err is high without rvalid");

  // all cores come out of reset running
  awake_after_reset: assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> core_awake_i == '1
  ) else $error("cores not all awake after reset release");

endmodule

bind ctrl_top ctrl_top_chk i_ctrl_top_chk (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .req_i        (reg_req_i),
  .rvalid_i     (reg_rvalid_o),
  .err_i        (reg_err_o),
  .core_awake_i (core_awake_o)
);

/* tb_clk_gen.sv */
// ##############################
// testbench clock and reset
// 4 ns clock, reset low for the
// first two rising edges
// ##############################

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // free running clock, 2 ns per half period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // release 1 ns after the second edge, away from the clock
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

/* ctrl_top.sv */
// ############################
// cluster control top level
// control registers driving
// the core sleep logic
// ############################

module ctrl_top
  import ctrl_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  // register bus request
  input  logic       reg_req_i,
  input  logic       reg_we_i,
  input  addr_t      reg_addr_i,
  input  data_t      reg_wdata_i,
  input  strb_t      reg_wstrb_i,
  // register bus response
  output logic       reg_rvalid_o,
  output data_t      reg_rdata_o,
  output logic       reg_err_o,
  // cores
  input  core_mask_t wfi_i,
  output core_mask_t core_awake_o
);

  // wake pulse from the wake-up register
  core_mask_t wake;

  ctrl_registers i_ctrl_registers (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (reg_req_i),
    .we_i     (reg_we_i),
    .addr_i   (reg_addr_i),
    .wdata_i  (reg_wdata_i),
    .wstrb_i  (reg_wstrb_i),
    .rvalid_o (reg_rvalid_o),
    .rdata_o  (reg_rdata_o),
    .err_o    (reg_err_o),
    .wake_o   (wake)
  );

  core_sleep_ctrl i_core_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .wake_i       (wake),
    .wfi_i        (wfi_i),
    .core_awake_o (core_awake_o)
  );

endmodule

/* core_sleep_ctrl.sv */
// ############################
// core sleep control
// per-core run/wait FSM with
// a pending wake bit
// ############################

module core_sleep_ctrl
  import ctrl_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  core_mask_t wake_i,
  input  core_mask_t wfi_i,
  output core_mask_t core_awake_o
);

  for (genvar c = 0; c < $bits(core_mask_t); c++) begin : g_core

    sleep_state_e state_d;
    sleep_state_e state_q;
    logic         pend_d;
    logic         pend_q;

    always_comb begin
      state_d = state_q;
      pend_d  = pend_q;
      unique case (state_q)
        SLEEP_RUN: begin
          if (wfi_i[c]) begin
            // an earlier or simultaneous wake cancels the wfi
            if (pend_q || wake_i[c]) begin
              pend_d = 1'b0;
            end else begin
              state_d = SLEEP_WAIT;
            end
          end else if (wake_i[c]) begin
            // remember the wake for the next wfi
            pend_d = 1'b1;
          end
        end
        SLEEP_WAIT: begin
          if (wake_i[c]) begin
            state_d = SLEEP_RUN;
            pend_d  = 1'b0;
          end
        end
        default: begin
          state_d = SLEEP_RUN;
          pend_d  = 1'b0;
        end
      endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        state_q <= SLEEP_RUN;
        pend_q  <= 1'b0;
      end else begin
        state_q <= state_d;
        pend_q  <= pend_d;
      end
    end

    // awake straight from the state flop
    assign core_awake_o[c] = (state_q == SLEEP_RUN);

  end

endmodule

/* ctrl_registers.sv */
// ############################
// cluster control registers
// register file plus wake-up
// decode into a core pulse
// ############################

`include "ctrl_macros.svh"

module ctrl_registers
  import ctrl_pkg::*;
  import ctrl_map_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  // register bus request
  input  logic       req_i,
  input  logic       we_i,
  input  addr_t      addr_i,
  input  data_t      wdata_i,
  input  strb_t      wstrb_i,
  // register bus response
  output logic       rvalid_o,
  output data_t      rdata_o,
  output logic       err_o,
  // one-cycle wake pulse per core
  output core_mask_t wake_o
);

  reg_bus_if bus ();

  reg_strb_t wr_active;
  reg_file_t reg_q;
  strb_t     wake_wr_q;
  data_t     wake_val;

  // this block is the bus master toward the register file
  assign bus.req   = req_i;
  assign bus.we    = we_i;
  assign bus.addr  = addr_i;
  assign bus.wdata = wdata_i;
  assign bus.wstrb = wstrb_i;

  assign rvalid_o = bus.rvalid;
  assign rdata_o  = bus.rdata;
  assign err_o    = bus.err;

  ctrl_regfile i_ctrl_regfile (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus         (bus),
    .wr_active_o (wr_active),
    .reg_q_o     (reg_q)
  );

  // delay the wake-up write by one cycle so the new value is stored
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wake_wr_q <= '0;
    end else begin
      wake_wr_q <= wr_active[REG_WAKE_UP];
    end
  end

  assign wake_val = reg_q[REG_WAKE_UP];

  // index below core count wakes one core, all ones wakes all
  always_comb begin
    wake_o = '0;
    if (|wake_wr_q) begin
      if (wake_val < data_t'(`CTRL_NUM_CORES)) begin
        wake_o = core_mask_t'(1) << wake_val;
      end else if (wake_val == '1) begin
        wake_o = '1;
      end
    end
  end

endmodule

/* ctrl_regfile.sv */
// ############################
// control register file
// strobed writes, read-only
// protection, error response
// ############################

module ctrl_regfile
  import ctrl_pkg::*;
  import ctrl_map_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  reg_bus_if.slave  bus,
  output reg_strb_t wr_active_o,
  output reg_file_t reg_q_o
);

  // address with the byte lane bits dropped
  addr_t     word_addr;
  reg_idx_t  idx;
  logic      hit;
  logic      refuse;
  reg_strb_t wr_active;
  reg_file_t reg_d;
  reg_file_t reg_q;
  logic      rvalid_q;
  logic      err_q;
  data_t     rdata_q;

  assign word_addr = {bus.addr[$bits(addr_t)-1:2], 2'b00};

  // offset to register index, anything else is outside the map
  always_comb begin
    hit = 1'b1;
    idx = REG_TCDM_START;
    case (word_addr)
      REG_OFF_TCDM_START: idx = REG_TCDM_START;
      REG_OFF_TCDM_END:   idx = REG_TCDM_END;
      REG_OFF_NUM_CORES:  idx = REG_NUM_CORES;
      REG_OFF_WAKE_UP:    idx = REG_WAKE_UP;
      default:            hit = 1'b0;
    endcase
  end

  // refused: out of map, or a write with strobes on a read-only word
  assign refuse = !hit || (bus.we && REG_READ_ONLY[idx] && (|bus.wstrb));

  // byte lanes being written this cycle
  always_comb begin
    wr_active = '0;
    if (bus.req && bus.we && !refuse) begin
      wr_active[idx] = bus.wstrb;
    end
  end

  // merge strobed bytes into the current image
  always_comb begin
    reg_d = reg_q;
    for (int r = 0; r < NUM_REGS; r++) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (wr_active[r][b]) begin
          reg_d[r][8*b +: 8] = bus.wdata[8*b +: 8];
        end
      end
    end
  end

  // read-only words never take a write, so they stay at their reset value
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      reg_q <= REG_RST_VAL;
    end else begin
      reg_q <= reg_d;
    end
  end

  // response handshake
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      err_q    <= bus.req && refuse;
    end
  end

  // read data, zero for writes and refused reads
  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we && !refuse) begin
      rdata_q <= reg_q[idx];
    end else begin
      rdata_q <= '0;
    end
  end

  assign bus.rvalid  = rvalid_q;
  assign bus.err     = err_q;
  assign bus.rdata   = rdata_q;
  assign wr_active_o = wr_active;
  assign reg_q_o     = reg_q;

endmodule

/* reg_bus_if.sv */
// ############################
// register bus
// one request per req cycle,
// response one cycle later
// ############################

interface reg_bus_if import ctrl_pkg::*; ();

  // request side
  logic  req;
  logic  we;
  addr_t addr;
  data_t wdata;
  strb_t wstrb;

  // response side, rdata is zero for writes
  logic  rvalid;
  data_t rdata;
  logic  err;

  modport master (
    output req, we, addr, wdata, wstrb,
    input  rvalid, rdata, err
  );

  modport slave (
    input  req, we, addr, wdata, wstrb,
    output rvalid, rdata, err
  );

endinterface

/* ctrl_map_pkg.sv */
// ############################
// control register map
// offsets, read-only mask and
// reset values of the block
// ############################

`include "ctrl_macros.svh"

package ctrl_map_pkg;

  import ctrl_pkg::*;

  localparam int unsigned NUM_REGS = 4;

  typedef logic [1:0] reg_idx_t;

  // all registers side by side, index 0 in the low word
  typedef data_t [NUM_REGS-1:0] reg_file_t;
  typedef strb_t [NUM_REGS-1:0] reg_strb_t;

  localparam reg_idx_t REG_TCDM_START = 2'd0;
  localparam reg_idx_t REG_TCDM_END   = 2'd1;
  localparam reg_idx_t REG_NUM_CORES  = 2'd2;
  localparam reg_idx_t REG_WAKE_UP    = 2'd3;

  // byte offsets on the bus, word aligned
  localparam addr_t REG_OFF_TCDM_START = addr_t'('h0);
  localparam addr_t REG_OFF_TCDM_END   = addr_t'('h4);
  localparam addr_t REG_OFF_NUM_CORES  = addr_t'('h8);
  localparam addr_t REG_OFF_WAKE_UP    = addr_t'('hc);

  // bit per register index, only wake-up is writable
  localparam logic [NUM_REGS-1:0] REG_READ_ONLY = 4'b0111;

  // concatenation runs from the top index down
  localparam reg_file_t REG_RST_VAL = {
    data_t'(0),
    data_t'(`CTRL_NUM_CORES),
    data_t'(`CTRL_TCDM_BASE + `CTRL_TCDM_SIZE),
    data_t'(`CTRL_TCDM_BASE)
  };

endpackage

/* ctrl_pkg.sv */
// ############################
// cluster control types
// bus vectors, core masks and
// the per-core sleep state
// ############################

`include "ctrl_macros.svh"

package ctrl_pkg;

  // register data word
  typedef logic [`CTRL_DATA_WIDTH-1:0] data_t;

  // byte address on the register bus
  typedef logic [`CTRL_ADDR_WIDTH-1:0] addr_t;

  // one enable per data byte
  typedef logic [`CTRL_DATA_WIDTH/8-1:0] strb_t;

  // one bit per core
  typedef logic [`CTRL_NUM_CORES-1:0] core_mask_t;

  // core is either running or parked in wfi
  typedef enum logic {
    SLEEP_RUN  = 1'b0,
    SLEEP_WAIT = 1'b1
  } sleep_state_e;

endpackage

/* ctrl_macros.svh */
// ############################
// cluster control parameters
// widths, core count and the
// fixed tcdm address window
// ############################

`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// register width in bits
`define CTRL_DATA_WIDTH 32

// register bus byte address width
`define CTRL_ADDR_WIDTH 8

// number of cores in the cluster
`define CTRL_NUM_CORES 8

// tcdm window, only visible as read-only registers
`define CTRL_TCDM_BASE 32'h1000_0000
`define CTRL_TCDM_SIZE 32'h0001_0000

`endif
